/* ariane_fpga.f */
ariane_fpga_pkg.sv
ariane_fpga_xbar.sv
ariane_fpga_bootrom.sv
ariane_fpga_clint.sv
ariane_fpga_board_io.sv
ariane_fpga_top.sv
ariane_fpga_chk.sv
tb_ariane_fpga.sv

/* Makefile */
# Verilator build and run for the FPGA uncore testbench

VERILATOR ?= verilator
TOP       ?= tb_ariane_fpga
FILELIST  ?= ariane_fpga.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG) || ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_ariane_fpga.sv */
// testbench for the FPGA uncore
// a table of bus accesses issued back to back, then directed checks of
// the fan PWM, mtime and both interrupt lines

`timescale 1ns/1ps

module tb_ariane_fpga;
  import ariane_fpga_pkg::*;

  localparam int PwmWaitCycles = 3 * 40;
  localparam int IrqWaitCycles = 12;
  localparam pwm_t FanDuties [3] = '{4'd0, 4'd5, 4'd15};

  logic  clk;
  logic  ndmreset_n;
  logic  req;
  logic  we;
  addr_t addr;
  strb_t be;
  data_t wdata;
  data_t rdata;
  logic  rvalid;
  logic  err;
  logic  timer_irq;
  logic  ipi;
  led_t  led;
  led_t  sw;
  logic  fan_pwm;

  int err_cnt = 0;
  int test_cnt = 0;
  int cycle_cnt = 0;
  int cycle_limit = 0;

  // stimulus table, one entry per bus access
  string t_name [$];
  logic  t_we [$];
  addr_t t_addr [$];
  strb_t t_be [$];
  data_t t_wdata [$];
  data_t t_exp [$];
  logic  t_err [$];

  ariane_fpga_top #(
    .RomWords ( RomWordsDefault )
  ) i_dut (
    .clk         ( clk        ),
    .ndmreset_n  ( ndmreset_n ),
    .req_i       ( req        ),
    .we_i        ( we         ),
    .addr_i      ( addr       ),
    .be_i        ( be         ),
    .wdata_i     ( wdata      ),
    .rdata_o     ( rdata      ),
    .rvalid_o    ( rvalid     ),
    .err_o       ( err        ),
    .timer_irq_o ( timer_irq  ),
    .ipi_o       ( ipi        ),
    .led_o       ( led        ),
    .sw_i        ( sw         ),
    .fan_pwm_o   ( fan_pwm    )
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // watchdog
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      $display("timeout: run stopped after %0d cycles", cycle_cnt);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // compare tasks and helpers
  // ------------------------------------------------------------
  task automatic check_data(string name, data_t exp, data_t act);
    if (act !== exp) begin
      $display("Error: %s expected %h actual %h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("Error: %s expected %b actual %b", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_leds(string name, led_t exp, led_t act);
    if (act !== exp) begin
      $display("Error: %s expected %h actual %h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic report_test(string name, int errs_before);
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("ok    %s", name);
    end else begin
      $display("fail  %s", name);
    end
  endtask

  task automatic add_step(string name, logic w, addr_t a, strb_t b, data_t d,
                          data_t exp, logic exp_err);
    t_name.push_back(name);
    t_we.push_back(w);
    t_addr.push_back(a);
    t_be.push_back(b);
    t_wdata.push_back(d);
    t_exp.push_back(exp);
    t_err.push_back(exp_err);
  endtask

  task automatic drive_bus(logic r, logic w, addr_t a, strb_t b, data_t d);
    req   = r;
    we    = w;
    addr  = a;
    be    = b;
    wdata = d;
  endtask

  // single access to a mapped register, response expected next cycle
  task automatic bus_access(string name, logic w, addr_t a, strb_t b, data_t d,
                            output data_t rd);
    @(posedge clk);
    #10;
    drive_bus(1'b1, w, a, b, d);
    @(posedge clk);
    #10;
    drive_bus(1'b0, 1'b0, '0, '0, '0);
    if (rvalid !== 1'b1 || err !== 1'b0) begin
      $display("%s: no clean bus response, rvalid %b err %b", name, rvalid, err);
      err_cnt++;
    end
    rd = rdata;
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial begin
    led_t  led_pat;
    data_t wd;
    data_t t1;
    data_t t2;
    data_t t3;
    data_t dummy;
    logic  seen;
    logic  samples [32];
    int    waited;
    int    start;
    int    high;
    int    errs;
    int    n;

    void'($urandom(32'h27f55b33));
    ndmreset_n = 1'b0;
    drive_bus(1'b0, 1'b0, '0, '0, '0);
    led_pat = led_t'($urandom());
    sw      = led_t'($urandom());
    wd      = {$urandom(), $urandom()};
    wd[7:0] = led_pat;

    for (int i = 0; i < RomWordsDefault; i++) begin
      add_step($sformatf("rom word %0d", i), 1'b0, RomBase + addr_t'(8 * i), 8'hff, '0,
               BootRomImage[i], 1'b0);
    end
    add_step("rom past end", 1'b0, RomBase + addr_t'(8 * RomWordsDefault), 8'hff, '0,
             '0, 1'b0);
    add_step("miss read low", 1'b0, 64'h0, 8'hff, '0, '0, 1'b1);
    add_step("miss write", 1'b1, 64'h1000_0000, 8'hff, wd, '0, 1'b1);
    add_step("miss past rom", 1'b0, RomBase + RomLength, 8'hff, '0, '0, 1'b1);
    add_step("miss high", 1'b0, 64'hffff_ffff_0000_0000, 8'hff, '0, '0, 1'b1);
    add_step("mtimecmp reset", 1'b0, ClintBase + ClintMtimecmpOfs, 8'hff, '0, '1, 1'b0);
    add_step("msip reset", 1'b0, ClintBase + ClintMsipOfs, 8'hff, '0, '0, 1'b0);
    add_step("fan reset", 1'b0, GpioBase + GpioFanOfs, 8'hff, '0, 64'hf, 1'b0);
    add_step("led write", 1'b1, GpioBase + GpioLedOfs, 8'h01, wd, '0, 1'b0);
    add_step("led read", 1'b0, GpioBase + GpioLedOfs, 8'hff, '0, {56'd0, led_pat}, 1'b0);
    // byte 0 masked, so the LEDs keep their value
    add_step("led masked write", 1'b1, GpioBase + GpioLedOfs, 8'hfe, ~wd, '0, 1'b0);
    add_step("led read after mask", 1'b0, GpioBase + GpioLedOfs, 8'hff, '0,
             {56'd0, led_pat}, 1'b0);
    add_step("switch read", 1'b0, GpioBase + GpioSwOfs, 8'hff, '0, {56'd0, sw}, 1'b0);
    n = t_name.size();
    cycle_limit = 4 * n + PwmWaitCycles + IrqWaitCycles + 200;

    repeat (16) @(posedge clk);
    #10;
    ndmreset_n = 1'b1;
    errs = err_cnt;
    check_flag("rvalid after reset", 1'b0, rvalid);
    check_flag("err after reset", 1'b0, err);
    check_flag("timer irq after reset", 1'b0, timer_irq);
    check_flag("ipi after reset", 1'b0, ipi);
    report_test("reset state", errs);

    // table entries back to back, each answered one cycle later
    for (int i = 0; i <= n; i++) begin
      @(posedge clk);
      #10;
      if (i > 0) begin
        errs = err_cnt;
        check_flag({t_name[i-1], " rvalid"}, 1'b1, rvalid);
        check_flag({t_name[i-1], " err"}, t_err[i-1], err);
        check_data(t_name[i-1], t_exp[i-1], rdata);
        report_test(t_name[i-1], errs);
      end
      if (i < n) begin
        drive_bus(1'b1, t_we[i], t_addr[i], t_be[i], t_wdata[i]);
      end else begin
        drive_bus(1'b0, 1'b0, '0, '0, '0);
      end
    end
    @(posedge clk);
    #10;
    errs = err_cnt;
    check_flag("extra response", 1'b0, rvalid);
    check_leds("led output", led_pat, led);
    report_test("one response per request, led output", errs);

    // fan PWM over sliding 16-cycle windows
    foreach (FanDuties[k]) begin
      errs = err_cnt;
      bus_access("fan write", 1'b1, GpioBase + GpioFanOfs, 8'h01, data_t'(FanDuties[k]), dummy);
      for (int i = 0; i < 32; i++) begin
        @(negedge clk);
        samples[i] = fan_pwm;
      end
      for (int s = 0; s <= 16; s++) begin
        high = 0;
        for (int i = 0; i < 16; i++) begin
          high += int'(samples[s+i]);
        end
        check_data($sformatf("fan pwm %0d window %0d", FanDuties[k], s),
                   data_t'(FanDuties[k]), data_t'(high));
      end
      report_test($sformatf("fan pwm %0d", FanDuties[k]), errs);
    end

    // mtime
    errs = err_cnt;
    bus_access("mtime read 1", 1'b0, ClintBase + ClintMtimeOfs, 8'hff, '0, t1);
    repeat (10) @(posedge clk);
    bus_access("mtime read 2", 1'b0, ClintBase + ClintMtimeOfs, 8'hff, '0, t2);
    check_flag("mtime advances", 1'b1, t2 > t1);
    bus_access("mtime clear", 1'b1, ClintBase + ClintMtimeOfs, 8'hff, '0, dummy);
    start = cycle_cnt;
    bus_access("mtime read 3", 1'b0, ClintBase + ClintMtimeOfs, 8'hff, '0, t3);
    check_flag("mtime small after clear", 1'b1, t3 <= data_t'((cycle_cnt - start) / 2));
    report_test("mtime", errs);

    // timer interrupt
    errs = err_cnt;
    bus_access("mtime read 4", 1'b0, ClintBase + ClintMtimeOfs, 8'hff, '0, t1);
    bus_access("mtimecmp set", 1'b1, ClintBase + ClintMtimecmpOfs, 8'hff, t1 + 64'd4, dummy);
    seen = timer_irq;
    waited = 0;
    while (!seen && waited < IrqWaitCycles) begin
      @(posedge clk);
      #10;
      seen = timer_irq;
      waited++;
    end
    if (!seen) begin
      $display("timer irq did not rise within %0d cycles", IrqWaitCycles);
      err_cnt++;
    end
    bus_access("mtimecmp max", 1'b1, ClintBase + ClintMtimecmpOfs, 8'hff, '1, dummy);
    check_flag("timer irq cleared", 1'b0, timer_irq);
    report_test("timer interrupt", errs);

    // software interrupt
    errs = err_cnt;
    bus_access("msip set", 1'b1, ClintBase + ClintMsipOfs, 8'h01, 64'd1, dummy);
    check_flag("ipi set", 1'b1, ipi);
    bus_access("msip clear", 1'b1, ClintBase + ClintMsipOfs, 8'h01, 64'd0, dummy);
    check_flag("ipi cleared", 1'b0, ipi);
    report_test("software interrupt", errs);

    $display("tests %0d, errors %0d", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* ariane_fpga_chk.sv */
// crossbar timing checks
// one response per request, errors only with a response and never
// more than one target strobe at a time

`timescale 1ns/1ps

module ariane_fpga_chk (
  input logic clk,
  input logic ndmreset_n,
  input logic req_i,
  input logic rvalid_i,
  input logic err_i,
  input logic rom_req_i,
  input logic clint_req_i,
  input logic gpio_req_i
);

  rvalid_follows_req: assert property (
    @(posedge clk) disable iff (!ndmreset_n) rvalid_i == $past(req_i)
  ) else $error("rvalid does not follow req by exactly one cycle");

  err_with_rvalid: assert property (
    @(posedge clk) disable iff (!ndmreset_n) err_i |-> rvalid_i
  ) else $error("err raised without rvalid");

  // decode is exclusive
  one_target: assert property (
    @(posedge clk) disable iff (!ndmreset_n) $onehot0({rom_req_i, clint_req_i, gpio_req_i})
  ) else $error("more than one target request at a time");

endmodule

bind ariane_fpga_xbar ariane_fpga_chk i_chk (
  .clk         ( clk         ),
  .ndmreset_n  ( ndmreset_n  ),
  .req_i       ( req_i       ),
  .rvalid_i    ( rvalid_o    ),
  .err_i       ( err_o       ),
  .rom_req_i   ( rom_req_o   ),
  .clint_req_i ( clint_req_o ),
  .gpio_req_i  ( gpio_req_o  )
);

/* ariane_fpga_top.sv */
// FPGA uncore top level
// external bus master into the crossbar, which serves the boot ROM,
// the CLINT and the board I/O

`timescale 1ns/1ps

module ariane_fpga_top #(
  parameter int unsigned RomWords = ariane_fpga_pkg::RomWordsDefault
) (
  input  logic                   clk,
  input  logic                   ndmreset_n,
  input  logic                   req_i,
  input  logic                   we_i,
  input  ariane_fpga_pkg::addr_t addr_i,
  input  ariane_fpga_pkg::strb_t be_i,
  input  ariane_fpga_pkg::data_t wdata_i,
  output ariane_fpga_pkg::data_t rdata_o,
  output logic                   rvalid_o,
  output logic                   err_o,
  output logic                   timer_irq_o,
  output logic                   ipi_o,
  output ariane_fpga_pkg::led_t  led_o,
  input  ariane_fpga_pkg::led_t  sw_i,
  output logic                   fan_pwm_o
);
  import ariane_fpga_pkg::*;

  logic  rom_req;
  logic  clint_req;
  logic  gpio_req;
  data_t rom_rdata;
  data_t clint_rdata;
  data_t gpio_rdata;

  // ----------------------------------------------------------
  // crossbar
  // ----------------------------------------------------------
  ariane_fpga_xbar i_xbar (
    .clk           ( clk         ),
    .ndmreset_n    ( ndmreset_n  ),
    .req_i         ( req_i       ),
    .we_i          ( we_i        ),
    .addr_i        ( addr_i      ),
    .rom_req_o     ( rom_req     ),
    .clint_req_o   ( clint_req   ),
    .gpio_req_o    ( gpio_req    ),
    .rom_rdata_i   ( rom_rdata   ),
    .clint_rdata_i ( clint_rdata ),
    .gpio_rdata_i  ( gpio_rdata  ),
    .rdata_o       ( rdata_o     ),
    .rvalid_o      ( rvalid_o    ),
    .err_o         ( err_o       )
  );

  // ----------------------------------------------------------
  // targets, sharing address, strobe and write data
  // ----------------------------------------------------------
  ariane_fpga_bootrom #(
    .RomWords ( RomWords )
  ) i_bootrom (
    .clk     ( clk       ),
    .req_i   ( rom_req   ),
    .addr_i  ( addr_i    ),
    .rdata_o ( rom_rdata )
  );

  ariane_fpga_clint i_clint (
    .clk         ( clk         ),
    .ndmreset_n  ( ndmreset_n  ),
    .req_i       ( clint_req   ),
    .we_i        ( we_i        ),
    .addr_i      ( addr_i      ),
    .be_i        ( be_i        ),
    .wdata_i     ( wdata_i     ),
    .rdata_o     ( clint_rdata ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  ariane_fpga_board_io i_board_io (
    .clk        ( clk        ),
    .ndmreset_n ( ndmreset_n ),
    .req_i      ( gpio_req   ),
    .we_i       ( we_i       ),
    .addr_i     ( addr_i     ),
    .be_i       ( be_i       ),
    .wdata_i    ( wdata_i    ),
    .rdata_o    ( gpio_rdata ),
    .led_o      ( led_o      ),
    .sw_i       ( sw_i       ),
    .fan_pwm_o  ( fan_pwm_o  )
  );

endmodule

/* ariane_fpga_board_io.sv */
// board I/O block
// LED register, DIP switch readback and the fan PWM setting with its
// 16-step PWM generator

`timescale 1ns/1ps

module ariane_fpga_board_io (
  input  logic                   clk,
  input  logic                   ndmreset_n,
  input  logic                   req_i,
  input  logic                   we_i,
  input  ariane_fpga_pkg::addr_t addr_i,
  input  ariane_fpga_pkg::strb_t be_i,
  input  ariane_fpga_pkg::data_t wdata_i,
  output ariane_fpga_pkg::data_t rdata_o,
  output ariane_fpga_pkg::led_t  led_o,
  input  ariane_fpga_pkg::led_t  sw_i,
  output logic                   fan_pwm_o
);
  import ariane_fpga_pkg::*;

  localparam int unsigned OfsBits = $clog2(GpioLength);

  logic [OfsBits-4:0] word_ofs;
  logic               sel_led;
  logic               sel_sw;
  logic               sel_fan;
  logic               wr_byte0;

  led_t  led_q;
  pwm_t  fan_q;
  pwm_t  pwm_cnt_q;
  data_t rdata_d;

  assign word_ofs = addr_i[OfsBits-1:3];
  assign sel_led  = word_ofs == GpioLedOfs[OfsBits-1:3];
  assign sel_sw   = word_ofs == GpioSwOfs[OfsBits-1:3];
  assign sel_fan  = word_ofs == GpioFanOfs[OfsBits-1:3];
  // both writable registers live in byte 0
  assign wr_byte0 = req_i && we_i && be_i[0];

  always_ff @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      led_q <= '0;
      fan_q <= '1;
    end else begin
      if (wr_byte0 && sel_led) begin
        led_q <= wdata_i[7:0];
      end
      if (wr_byte0 && sel_fan) begin
        fan_q <= wdata_i[3:0];
      end
    end
  end

  // ----------------------------------------------------------
  // fan PWM, high for fan_q cycles out of every 16
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      pwm_cnt_q <= '0;
    end else begin
      pwm_cnt_q <= pwm_cnt_q + 4'd1;
    end
  end

  assign fan_pwm_o = pwm_cnt_q < fan_q;

  // switches are read only
  always_comb begin
    rdata_d = '0;
    if (sel_led) begin
      rdata_d = {56'd0, led_q};
    end else if (sel_sw) begin
      rdata_d = {56'd0, sw_i};
    end else if (sel_fan) begin
      rdata_d = {60'd0, fan_q};
    end
  end

  always_ff @(posedge clk) begin
    if (req_i) begin
      rdata_o <= rdata_d;
    end
  end

  assign led_o = led_q;

endmodule

/* ariane_fpga_clint.sv */
// core-local interruptor
// real-time tick at half the clock rate drives mtime, compared against
// mtimecmp for the timer interrupt; msip bit 0 is the software interrupt

`timescale 1ns/1ps

module ariane_fpga_clint (
  input  logic                   clk,
  input  logic                   ndmreset_n,
  input  logic                   req_i,
  input  logic                   we_i,
  input  ariane_fpga_pkg::addr_t addr_i,
  input  ariane_fpga_pkg::strb_t be_i,
  input  ariane_fpga_pkg::data_t wdata_i,
  output ariane_fpga_pkg::data_t rdata_o,
  output logic                   timer_irq_o,
  output logic                   ipi_o
);
  import ariane_fpga_pkg::*;

  // region base is aligned to the region size rounded up
  localparam int unsigned OfsBits = $clog2(ClintLength);

  logic [OfsBits-4:0] word_ofs;
  logic               sel_msip;
  logic               sel_mtimecmp;
  logic               sel_mtime;
  logic               wr;

  logic  tick_q;
  logic  msip_q;
  data_t mtime_q;
  data_t mtimecmp_q;
  data_t rdata_d;

  function automatic data_t merge_bytes(data_t old, data_t wdata, strb_t be);
    data_t res;
    res = old;
    for (int i = 0; i < 8; i++) begin
      if (be[i]) begin
        res[8*i +: 8] = wdata[8*i +: 8];
      end
    end
    return res;
  endfunction

  // ----------------------------------------------------------
  // register select
  // ----------------------------------------------------------
  assign word_ofs     = addr_i[OfsBits-1:3];
  assign sel_msip     = word_ofs == ClintMsipOfs[OfsBits-1:3];
  assign sel_mtimecmp = word_ofs == ClintMtimecmpOfs[OfsBits-1:3];
  assign sel_mtime    = word_ofs == ClintMtimeOfs[OfsBits-1:3];
  assign wr           = req_i && we_i;

  // divide clk by two for the real-time tick
  always_ff @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      tick_q <= 1'b0;
    end else begin
      tick_q <= ~tick_q;
    end
  end

  always_ff @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      msip_q     <= 1'b0;
      mtime_q    <= '0;
      mtimecmp_q <= '1;
    end else begin
      if (wr && sel_msip && be_i[0]) begin
        msip_q <= wdata_i[0];
      end
      if (wr && sel_mtimecmp) begin
        mtimecmp_q <= merge_bytes(mtimecmp_q, wdata_i, be_i);
      end
      // a software write wins over the tick
      if (wr && sel_mtime) begin
        mtime_q <= merge_bytes(mtime_q, wdata_i, be_i);
      end else if (tick_q) begin
        mtime_q <= mtime_q + 64'd1;
      end
    end
  end

  // ----------------------------------------------------------
  // read port
  // ----------------------------------------------------------
  always_comb begin
    rdata_d = '0;
    if (sel_msip) begin
      rdata_d = {63'd0, msip_q};
    end else if (sel_mtimecmp) begin
      rdata_d = mtimecmp_q;
    end else if (sel_mtime) begin
      rdata_d = mtime_q;
    end
  end

  always_ff @(posedge clk) begin
    if (req_i) begin
      rdata_o <= rdata_d;
    end
  end

  assign timer_irq_o = mtime_q >= mtimecmp_q;
  assign ipi_o       = msip_q;

endmodule

/* ariane_fpga_bootrom.sv */
// boot ROM
// serves the boot image word by word, one cycle after the request

`timescale 1ns/1ps

module ariane_fpga_bootrom #(
  parameter int unsigned RomWords = ariane_fpga_pkg::RomWordsDefault
) (
  input  logic                   clk,
  input  logic                   req_i,
  input  ariane_fpga_pkg::addr_t addr_i,
  output ariane_fpga_pkg::data_t rdata_o
);
  import ariane_fpga_pkg::*;

  // word index over the whole region
  localparam int unsigned IdxBits = $clog2(RomLength / 8);
  // bits that select a word of the stored image
  localparam int unsigned ImgBits = $clog2(RomWordsDefault);

  logic [IdxBits-1:0] word_idx;
  data_t              rdata_d;

  assign word_idx = addr_i[3 +: IdxBits];

  // zero beyond the configured size and beyond the stored image
  always_comb begin
    rdata_d = '0;
    if ((word_idx < RomWords) && (word_idx < RomWordsDefault)) begin
      rdata_d = BootRomImage[word_idx[ImgBits-1:0]];
    end
  end

  always_ff @(posedge clk) begin
    if (req_i) begin
      rdata_o <= rdata_d;
    end
  end

endmodule

/* ariane_fpga_xbar.sv */
// uncore crossbar
// decodes every request against the fixed region table, raises one
// target strobe and returns that target's data one cycle later

`timescale 1ns/1ps

module ariane_fpga_xbar (
  input  logic                   clk,
  input  logic                   ndmreset_n,
  input  logic                   req_i,
  input  logic                   we_i,
  input  ariane_fpga_pkg::addr_t addr_i,
  output logic                   rom_req_o,
  output logic                   clint_req_o,
  output logic                   gpio_req_o,
  input  ariane_fpga_pkg::data_t rom_rdata_i,
  input  ariane_fpga_pkg::data_t clint_rdata_i,
  input  ariane_fpga_pkg::data_t gpio_rdata_i,
  output ariane_fpga_pkg::data_t rdata_o,
  output logic                   rvalid_o,
  output logic                   err_o
);
  import ariane_fpga_pkg::*;

  region_e region_d;
  region_e region_q;
  logic    rvalid_q;
  logic    we_q;

  // base compare first so the subtraction cannot wrap
  function automatic logic hit(addr_t addr, addr_t base, addr_t length);
    return (addr >= base) && ((addr - base) < length);
  endfunction

  // ----------------------------------------------------------
  // request side
  // ----------------------------------------------------------
  always_comb begin
    region_d = REGION_NONE;
    if (hit(addr_i, RomBase, RomLength)) begin
      region_d = REGION_ROM;
    end else if (hit(addr_i, ClintBase, ClintLength)) begin
      region_d = REGION_CLINT;
    end else if (hit(addr_i, GpioBase, GpioLength)) begin
      region_d = REGION_GPIO;
    end
  end

  assign rom_req_o   = req_i && (region_d == REGION_ROM);
  assign clint_req_o = req_i && (region_d == REGION_CLINT);
  assign gpio_req_o  = req_i && (region_d == REGION_GPIO);

  // ----------------------------------------------------------
  // response side
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rvalid_q <= 1'b0;
      we_q     <= 1'b0;
      region_q <= REGION_NONE;
    end else begin
      rvalid_q <= req_i;
      if (req_i) begin
        we_q     <= we_i;
        region_q <= region_d;
      end
    end
  end

  // writes and misses return zero
  always_comb begin
    rdata_o = '0;
    if (rvalid_q && !we_q) begin
      case (region_q)
        REGION_ROM:   rdata_o = rom_rdata_i;
        REGION_CLINT: rdata_o = clint_rdata_i;
        REGION_GPIO:  rdata_o = gpio_rdata_i;
        default:      rdata_o = '0;
      endcase
    end
  end

  assign rvalid_o = rvalid_q;
  assign err_o    = rvalid_q && (region_q == REGION_NONE);

endmodule

/* ariane_fpga_pkg.sv */
// FPGA uncore shared definitions
// bus widths, address map, register offsets and the boot image
// used by the crossbar, the targets and the testbench

package ariane_fpga_pkg;

  typedef logic [63:0] addr_t;
  typedef logic [63:0] data_t;
  typedef logic [7:0]  strb_t;
  typedef logic [7:0]  led_t;
  typedef logic [3:0]  pwm_t;

  // decoded bus target
  typedef enum logic [1:0] {
    REGION_ROM,
    REGION_CLINT,
    REGION_GPIO,
    REGION_NONE
  } region_e;

  // ----------------------------------------------------------
  // memory map
  // ----------------------------------------------------------
  localparam addr_t RomBase     = 64'h0000_0000_0001_0000;
  localparam addr_t RomLength   = 64'h0000_0000_0001_0000;
  localparam addr_t ClintBase   = 64'h0000_0000_0200_0000;
  localparam addr_t ClintLength = 64'h0000_0000_000C_0000;
  localparam addr_t GpioBase    = 64'h0000_0000_4000_0000;
  localparam addr_t GpioLength  = 64'h0000_0000_0000_1000;

  // register offsets inside their region
  localparam addr_t ClintMsipOfs     = 64'h0000;
  localparam addr_t ClintMtimecmpOfs = 64'h4000;
  localparam addr_t ClintMtimeOfs    = 64'hBFF8;
  localparam addr_t GpioLedOfs       = 64'h00;
  localparam addr_t GpioSwOfs        = 64'h08;
  localparam addr_t GpioFanOfs       = 64'h10;

  // ----------------------------------------------------------
  // boot image, two instructions per word, low half first
  // ----------------------------------------------------------
  localparam int unsigned RomWordsDefault = 16;

  localparam data_t BootRomImage [RomWordsDefault] = '{
    64'h0202_8593_0000_0297,
    64'h0010_0413_f140_2573,
    64'h0004_2023_0204_1413,
    64'h0000_8067_3040_0073,
    64'h1050_0073_0080_0313,
    64'h3043_2073_ffdf_f06f,
    64'h0000_0013_0000_0013,
    64'h0000_0013_0000_0013,
    64'h0000_0013_0000_0013,
    64'h0000_0013_0000_0013,
    64'h0000_0013_0000_0013,
    64'h0000_0013_0000_0013,
    64'h0000_0013_0000_0013,
    64'h0000_0013_0000_0013,
    64'h0000_0000_0000_0000,
    64'h8000_0000_0000_0000
  };

endpackage
